// File: logic/lane_params.svh
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// number of client lanes, keep a power of two so lane numbers wrap
`define LANES 4

// operand and result width
`define OPND_W 8

// bits needed for a lane number
`define LANE_W 2

`endif

// File: logic/lane_pkg.sv
`include "lane_params.svh"

package lane_pkg;

  // command opcodes as seen on the client lanes
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MIN = 2'd2,
    OP_CMP = 2'd3
  } opcode_e;

  typedef struct packed {
    opcode_e             op;
    logic [`OPND_W-1:0]  a;
    logic [`OPND_W-1:0]  b;
  } cmd_t;

  // one-hot style ALU controls, all zero means add
  typedef struct packed {
    logic                sub_sel; // adder subtracts
    logic                min_sel; // pick the smaller operand
    logic                cmp_sel; // output the compare code
    logic [`OPND_W-1:0]  a;
    logic [`OPND_W-1:0]  b;
  } dec_t;

  typedef struct packed {
    logic [`OPND_W-1:0]  value;
    logic                z;
    logic                n;
  } res_t;

endpackage

// File: logic/stage_if.sv
`timescale 1ns/1ps
`include "lane_params.svh"

// one valid/stall link between two pipeline stages
interface stage_if #(parameter type payload_t = logic);

  logic               valid; // item present on lane/data
  logic               stall; // from the sink, do not send
  logic [`LANE_W-1:0] lane;  // source lane of the item
  payload_t           data;

  modport source (
    output valid, lane, data,
    input  stall
  );

  modport sink (
    input  valid, lane, data,
    output stall
  );

endinterface

// File: logic/lane_arbiter.sv
`timescale 1ns/1ps
`include "lane_params.svh"

module lane_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`LANES-1:0]             in_valid,
  input  lane_pkg::cmd_t [`LANES-1:0]   in_cmd,
  output logic [`LANES-1:0]             in_stall,
  stage_if.source                       arb
);

  logic [`LANE_W-1:0] ptr;      // round-robin start lane
  logic [`LANE_W-1:0] idx;
  logic [`LANE_W-1:0] gnt_lane;
  logic               gnt_hit;  // some lane is requesting
  logic               load;     // output register free this cycle
  logic               take;     // a lane transfers on this edge

  // register is empty or drains this cycle
  assign load = ~(arb.valid & arb.stall);
  assign take = load & gnt_hit;

  // first requesting lane at or after the pointer
  always_comb begin
    gnt_lane = ptr;
    gnt_hit  = 1'b0;
    idx      = ptr;
    for (int i = 0; i < `LANES; i++) begin
      idx = ptr + i[`LANE_W-1:0]; // wraps around the lane count
      if (!gnt_hit && in_valid[idx]) begin
        gnt_lane = idx;
        gnt_hit  = 1'b1;
      end
    end
  end

  // requesting lanes that lose, or that hit a full stage, are held off
  always_comb begin
    for (int i = 0; i < `LANES; i++) begin
      in_stall[i] = in_valid[i] & ~(take && (gnt_lane == i));
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ptr       <= '0;
      arb.valid <= 1'b0;
    end else begin
      if (load)
        arb.valid <= gnt_hit;
      if (take)
        ptr <= gnt_lane + 1'b1; // next search starts after the winner
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      arb.data <= in_cmd[gnt_lane];
      arb.lane <= gnt_lane;
    end
  end

endmodule

// File: logic/op_decode.sv
`timescale 1ns/1ps

module op_decode (
  input  logic    clk,
  input  logic    rst,
  stage_if.sink   arb,
  stage_if.source dec
);

  logic           load;     // output register free
  lane_pkg::dec_t dec_n;

  assign load = ~(dec.valid & dec.stall);

  // hold the arbiter while our register is full and blocked
  assign arb.stall = ~load;

  // opcode to ALU selects
  always_comb begin
    dec_n.sub_sel = 1'b0;
    dec_n.min_sel = 1'b0;
    dec_n.cmp_sel = 1'b0;
    dec_n.a       = arb.data.a;
    dec_n.b       = arb.data.b;
    case (arb.data.op)
      lane_pkg::OP_ADD: ; // adder default
      lane_pkg::OP_SUB: dec_n.sub_sel = 1'b1;
      lane_pkg::OP_MIN: dec_n.min_sel = 1'b1;
      lane_pkg::OP_CMP: dec_n.cmp_sel = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst)
      dec.valid <= 1'b0;
    else if (load)
      dec.valid <= arb.valid;
  end

  // payload, lane passes straight through
  always_ff @(posedge clk) begin
    if (load && arb.valid) begin
      dec.data <= dec_n;
      dec.lane <= arb.lane;
    end
  end

endmodule

// File: logic/alu_execute.sv
`timescale 1ns/1ps
`include "lane_params.svh"

module alu_execute (
  input  logic    clk,
  input  logic    rst,
  stage_if.sink   dec,
  stage_if.source exe
);

  logic               load;
  logic [`OPND_W-1:0] sum;      // add or subtract, wraps
  logic [`OPND_W-1:0] min_val;
  logic [`OPND_W-1:0] cmp_code;
  lane_pkg::res_t     res_n;

  assign load      = ~(exe.valid & exe.stall);
  assign dec.stall = ~load;

  assign sum     = dec.data.sub_sel ? (dec.data.a - dec.data.b)
                                    : (dec.data.a + dec.data.b);
  assign min_val = (dec.data.a < dec.data.b) ? dec.data.a : dec.data.b;

  // 0 equal, 1 a greater, 2 b greater
  always_comb begin
    if (dec.data.a == dec.data.b)
      cmp_code = `OPND_W'd0;
    else if (dec.data.a > dec.data.b)
      cmp_code = `OPND_W'd1;
    else
      cmp_code = `OPND_W'd2;
  end

  always_comb begin
    if (dec.data.cmp_sel)
      res_n.value = cmp_code;
    else if (dec.data.min_sel)
      res_n.value = min_val;
    else
      res_n.value = sum;
    res_n.z = (res_n.value == '0);
    res_n.n = res_n.value[`OPND_W-1]; // sign bit of the result
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst)
      exe.valid <= 1'b0;
    else if (load)
      exe.valid <= dec.valid;
  end

  always_ff @(posedge clk) begin
    if (load && dec.valid) begin
      exe.data <= res_n;
      exe.lane <= dec.lane;
    end
  end

endmodule

// File: logic/skid_buf.sv
`timescale 1ns/1ps
`include "lane_params.svh"

// one-entry skid: upstream sees the downstream stall one cycle late,
// the item that slips through in that cycle is parked here
module skid_buf #(parameter type payload_t = logic) (
  input  logic               clk,
  input  logic               rst,
  stage_if.sink              up,
  output logic               valid,
  input  logic               stall,
  output logic [`LANE_W-1:0] lane,
  output payload_t           data
);

  logic               stall_q;   // registered downstream stall
  logic               tmp_valid; // parked item present
  logic               tmp_valid_n;
  logic [`LANE_W-1:0] tmp_lane;
  payload_t           tmp_data;

  assign up.stall = stall_q;

  // upstream item only offered when it is sure to leave upstream this edge
  assign valid = tmp_valid | (up.valid & ~stall_q);
  assign data  = tmp_valid ? tmp_data : up.data; // parked item goes first
  assign lane  = tmp_valid ? tmp_lane : up.lane;

  // park on a fresh stall, keep while stalled, drop once taken
  assign tmp_valid_n = stall ? (stall_q ? tmp_valid : up.valid) : 1'b0;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stall_q   <= 1'b0;
      tmp_valid <= 1'b0;
    end else begin
      stall_q   <= stall;
      tmp_valid <= tmp_valid_n;
    end
  end

  // buffer is always empty while stall_q is low
  always_ff @(posedge clk) begin
    if (!stall_q) begin
      tmp_data <= up.data;
      tmp_lane <= up.lane;
    end
  end

endmodule

// File: logic/lane_alu_top.sv
`timescale 1ns/1ps
`include "lane_params.svh"

module lane_alu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`LANES-1:0]           in_valid,
  input  lane_pkg::cmd_t [`LANES-1:0] in_cmd,
  output logic [`LANES-1:0]           in_stall,
  output logic                        out_valid,
  input  logic                        out_stall,
  output logic [`LANE_W-1:0]          out_lane,
  output logic [`OPND_W-1:0]          out_value,
  output logic                        out_z,
  output logic                        out_n
);

  lane_pkg::res_t out_res;

  stage_if #(.payload_t(lane_pkg::cmd_t)) arb_if ();
  stage_if #(.payload_t(lane_pkg::dec_t)) dec_if ();
  stage_if #(.payload_t(lane_pkg::res_t)) exe_if ();

  lane_arbiter arb_i (
    .clk,
    .rst,
    .in_valid,
    .in_cmd,
    .in_stall,
    .arb      (arb_if.source)
  );

  op_decode dec_i (
    .clk,
    .rst,
    .arb (arb_if.sink),
    .dec (dec_if.source)
  );

  alu_execute exe_i (
    .clk,
    .rst,
    .dec (dec_if.sink),
    .exe (exe_if.source)
  );

  // result stage
  skid_buf #(.payload_t(lane_pkg::res_t)) skid_i (
    .clk,
    .rst,
    .up    (exe_if.sink),
    .valid (out_valid),
    .stall (out_stall),
    .lane  (out_lane),
    .data  (out_res)
  );

  assign out_value = out_res.value;
  assign out_z     = out_res.z;
  assign out_n     = out_res.n;

endmodule

// File: dv/lane_alu_assertions.sv
`timescale 1ns/1ps
`include "lane_params.svh"

// reference queue of granted commands plus handshake checks on the top level ports
module lane_alu_assertions (
  input logic                        clk,
  input logic                        rst,
  input logic [`LANES-1:0]           in_valid,
  input lane_pkg::cmd_t [`LANES-1:0] in_cmd,
  input logic [`LANES-1:0]           in_stall,
  input logic                        out_valid,
  input logic                        out_stall,
  input logic [`LANE_W-1:0]          out_lane,
  input logic [`OPND_W-1:0]          out_value,
  input logic                        out_z,
  input logic                        out_n
);

  typedef struct packed {
    logic [`LANE_W-1:0] lane;
    lane_pkg::cmd_t     cmd;
  } entry_t;

  entry_t             q[$];       // accepted, not yet delivered, oldest first
  int                 q_cnt;
  int                 err_cnt = 0;
  logic [`LANES-1:0]  acc_vec;    // lanes transferring on this edge
  logic [`LANE_W-1:0] acc_lane;
  logic [`LANE_W-1:0] last_lane;  // lane of the previous grant
  logic [`LANE_W+$bits(lane_pkg::res_t)-1:0] exp_res; // lane, value, z, n
  logic               seen_cmd;
  logic               lone_acc;   // accept into an empty pipeline, no stall

  // expected result of one command
  function automatic lane_pkg::res_t model_result(lane_pkg::cmd_t c);
    lane_pkg::res_t r;
    case (c.op)
      lane_pkg::OP_ADD: r.value = c.a + c.b;
      lane_pkg::OP_SUB: r.value = c.a - c.b; // wraps modulo 256
      lane_pkg::OP_MIN: r.value = (c.a < c.b) ? c.a : c.b;
      default:          r.value = (c.a == c.b) ? `OPND_W'd0
                                : (c.a > c.b) ? `OPND_W'd1 : `OPND_W'd2;
    endcase
    r.z = (r.value == '0);
    r.n = r.value[`OPND_W-1];
    return r;
  endfunction

  assign acc_vec  = in_valid & ~in_stall;
  assign lone_acc = (acc_vec != '0) && (q_cnt == 0) && !out_stall;

  always_comb begin
    acc_lane = '0;
    for (int k = 0; k < `LANES; k++)
      if (acc_vec[k])
        acc_lane = k[`LANE_W-1:0];
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      q.delete();
      last_lane <= '1; // so lane 0 is next in line
      seen_cmd  <= 1'b0;
    end else begin
      if (out_valid && !out_stall && q.size() > 0)
        void'(q.pop_front());
      if (acc_vec != '0) begin
        q.push_back(entry_t'{acc_lane, in_cmd[acc_lane]});
        last_lane <= acc_lane;
      end
      if (in_valid != '0)
        seen_cmd <= 1'b1;
    end
    q_cnt   <= q.size();
    exp_res <= (q.size() > 0) ? {q[0].lane, model_result(q[0].cmd)} : '0;
  end

  a_result: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_stall |-> q_cnt > 0 && {out_lane, out_value, out_z, out_n} == exp_res)
  else begin
    err_cnt++;
    $error("Mismatch at %0t: {out_lane,out_value,out_z,out_n} expected %0h, got %0h",
      $time, $sampled(exp_res), $sampled({out_lane, out_value, out_z, out_n}));
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && out_stall |=> out_valid && $stable({out_lane, out_value, out_z, out_n}))
  else begin
    err_cnt++;
    $error("output dropped or changed while held by out_stall at %0t", $time);
  end

  // with every lane requesting the grant moves on by one lane
  a_rotate: assert property (@(posedge clk) disable iff (rst)
    in_valid == '1 && acc_vec != '0 |-> acc_lane == last_lane + `LANE_W'd1)
  else begin
    err_cnt++;
    $error("Mismatch at %0t: granted lane expected %0d, got %0d",
      $time, $sampled(last_lane) + `LANE_W'd1, $sampled(acc_lane));
  end

  a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(acc_vec))
  else begin
    err_cnt++;
    $error("more than one lane was accepted in one cycle at %0t", $time);
  end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    $past(lone_acc, 3) && !$past(out_stall, 2) && !$past(out_stall)
      |-> out_valid && out_lane == $past(acc_lane, 3))
  else begin
    err_cnt++;
    $error("lone command was not delivered 3 cycles after acceptance at %0t", $time);
  end

  a_idle: assert property (@(posedge clk) disable iff (rst)
    !seen_cmd && in_valid == '0 |-> !out_valid && in_stall == '0)
  else begin
    err_cnt++;
    $error("output valid or lane stall raised before any command at %0t", $time);
  end

endmodule

// File: dv/lane_alu_tb.sv
`timescale 1ns/1ps
`include "lane_params.svh"

module lane_alu_tb;

  logic                        clk;
  logic                        rst;
  logic [`LANES-1:0]           in_valid;
  lane_pkg::cmd_t [`LANES-1:0] in_cmd;
  logic [`LANES-1:0]           in_stall;
  logic                        out_valid;
  logic                        out_stall;
  logic [`LANE_W-1:0]          out_lane;
  logic [`OPND_W-1:0]          out_value;
  logic                        out_z;
  logic                        out_n;
  logic [31:0]                 lfsr;
  int                          accepted;
  int                          idle_cycles; // cycles since the last accept

  lane_alu_top dut_i (.*);

  bind lane_alu_top lane_alu_assertions chk_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Errors found");
    $fatal(1, "timeout while waiting for %s", what);
  endtask

  // fresh command for one lane, equal operands now and then so compare hits 0
  task automatic new_cmd(input int l, input logic force_valid);
    logic [31:0]    r;
    lane_pkg::cmd_t c;
    take_bits(18, r);
    c = r[17:0];
    take_bits(2, r);
    if (r[1:0] == 2'b00)
      c.b = c.a;
    in_cmd[l] <= c;
    take_bits(2, r);
    in_valid[l] <= force_valid || (r[1:0] != 2'b00);
  endtask

  task automatic run_cycle(input logic fair);
    logic [31:0] r;
    @(posedge clk);
    take_bits(2, r);
    out_stall <= !fair && (r[1:0] == 2'b00); // about one cycle in four
    for (int l = 0; l < `LANES; l++) begin
      if (in_valid[l] && !in_stall[l]) begin
        accepted++;
        idle_cycles = 0;
        new_cmd(l, fair);
      end else if (!in_valid[l]) begin
        new_cmd(l, fair);
      end
    end
    idle_cycles++;
    if (idle_cycles > 64)
      stop_on_timeout("a command to be accepted");
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 200)
        stop_on_timeout("the pipeline to drain");
    end while (dut_i.chk_i.q_cnt != 0);
  endtask

  always @(posedge clk) begin
    if (dut_i.chk_i.err_cnt != 0) begin
      $display("Errors found");
      $fatal(1, "a checker assertion failed");
    end
  end

  initial begin
    int n;
    lfsr        = 32'hf6d5;
    rst         = 1'b1;
    in_valid    = '0;
    in_cmd      = '0;
    out_stall   = 1'b0;
    accepted    = 0;
    idle_cycles = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk); // idle lanes after reset
    // lone subtract that wraps, through the empty pipeline
    in_cmd[0]   <= lane_pkg::cmd_t'{lane_pkg::OP_SUB, 8'h03, 8'h05};
    in_valid[0] <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 20)
        stop_on_timeout("the first command to be accepted");
    end while (!(in_valid[0] && !in_stall[0]));
    in_valid[0] <= 1'b0;
    wait_drain();
    while (accepted < 560)
      run_cycle(1'b0);
    while (accepted < 600)
      run_cycle(1'b1); // all lanes busy, no back-pressure
    in_valid  <= '0;
    out_stall <= 1'b0;
    wait_drain();
    repeat (2) @(posedge clk);
    if (dut_i.chk_i.err_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "the checker counted failures");
    end
  end

endmodule

// File: vlog.f
+incdir+logic
logic/lane_pkg.sv
logic/stage_if.sv
logic/lane_arbiter.sv
logic/op_decode.sv
logic/alu_execute.sv
logic/skid_buf.sv
logic/lane_alu_top.sv
dv/lane_alu_assertions.sv
dv/lane_alu_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module lane_alu_tb \
  -o lane_alu_sim \
  && ./obj_dir/lane_alu_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "No errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
